/* vtb_pkg.sv */
// shared widths, block count and entry operation encoding for the vector load/store buffer entry

package vtb_pkg;

  // ====================
  // data path widths
  // ====================

  // entry data word
  localparam int DATA_W = 64;

  // memory returns data in this many blocks
  localparam int BLK_NUM = 4;

  // one mask bit per data byte
  localparam int BYTE_NUM = DATA_W / 8;

  // ====================
  // register fields
  // ====================

  // vector register field of the entry
  localparam int VREG_W = 7;

  // fp register number, same as vreg bits 6..2
  localparam int FREG_W = 5;

  // ====================
  // entry operation
  // ====================

  // bit 1 marks a store, bit 0 the fp register path
  typedef enum logic [1:0] {
    OP_LOAD      = 2'b00,
    OP_FLS_LOAD  = 2'b01,
    OP_STORE     = 2'b10,
    OP_FLS_STORE = 2'b11
  } vtb_op_e;

endpackage

/* vtb_fwd_match.sv */
// store forwarding match of both register write-back buses and forwarded data select

`timescale 1ns/1ps

module vtb_fwd_match #(
  parameter int DATA_W = vtb_pkg::DATA_W
) (
  input  logic                      fwd_pend,
  input  logic                      fls_wb_vld,
  input  logic [vtb_pkg::FREG_W-1:0] fls_reg,
  input  logic [DATA_W-1:0]         fls_data,
  input  logic                      fp_wb_vld,
  input  logic [vtb_pkg::FREG_W-1:0] fp_wb_reg,
  input  logic [DATA_W-1:0]         fp_wb_data,
  input  logic [vtb_pkg::VREG_W-1:0] entry_vreg,
  output logic                      fwd_hit,
  output logic                      fp_sel,
  output logic [DATA_W-1:0]         fwd_data
);

  import vtb_pkg::*;

  logic [FREG_W-1:0] entry_freg;
  logic              fls_hit;
  logic              fp_hit;

  // fp register number is the upper part of the vreg group
  assign entry_freg = entry_vreg[VREG_W-1 -: FREG_W];

  assign fls_hit = fls_wb_vld && (fls_reg == entry_freg);
  assign fp_hit  = fp_wb_vld && (fp_wb_reg == entry_freg);

  // raw hit, qualified by the entry state in the control block
  assign fwd_hit = fls_hit || fp_hit;

  // fp bus wins when both buses match
  assign fwd_data = fp_hit ? fp_wb_data : fls_data;

  // only report the fp bus for an entry that waits for data
  assign fp_sel = fwd_pend && fp_hit;

endmodule

/* vtb_data_blk.sv */
// one entry data block with create merge, store forwarding and masked memory write

`timescale 1ns/1ps

module vtb_data_blk #(
  parameter int BLK_W = 16
) (
  input  logic               entry_clk,
  input  logic               create_vld,
  input  logic               wen,
  input  logic               fwd_vld,
  input  logic [BLK_W-1:0]   create_data,
  input  logic [BLK_W-1:0]   lsu_data,
  input  logic [BLK_W-1:0]   fwd_data,
  input  logic [BLK_W/8-1:0] create_mask,
  input  logic [BLK_W/8-1:0] merge_mask,
  input  logic [BLK_W/8-1:0] active_mask,
  output logic [BLK_W-1:0]   blk_data
);

  localparam int BLK_BYTE = BLK_W / 8;

  logic [BLK_W-1:0] create_bits;
  logic [BLK_W-1:0] merge_bits;
  logic [BLK_W-1:0] active_bits;
  logic [BLK_W-1:0] create_wdata;
  logic [BLK_W-1:0] mem_wdata;

  // byte masks to bit masks
  always_comb
  begin
    create_bits = '0;
    merge_bits  = '0;
    active_bits = '0;
    for (int i = 0; i < BLK_BYTE; i++)
    begin
      create_bits[i*8 +: 8] = {8{create_mask[i]}};
      merge_bits[i*8 +: 8]  = {8{merge_mask[i]}};
      active_bits[i*8 +: 8] = {8{active_mask[i]}};
    end
  end

  // ====================
  // next data
  // ====================

  // memory data arriving with the create fills the masked bytes,
  // otherwise bytes already returned by memory are kept
  assign create_wdata = wen ? (create_data & ~create_bits) | (lsu_data & create_bits)
                            : (create_data & ~merge_bits) | (blk_data & merge_bits);

  assign mem_wdata = (lsu_data & active_bits) | (blk_data & ~active_bits);

  // create, then forward, then memory write
  always_ff @(posedge entry_clk)
  begin
    if (create_vld)
    begin
      blk_data <= create_wdata;
    end
    else if (fwd_vld)
    begin
      blk_data <= fwd_data;
    end
    else if (wen)
    begin
      blk_data <= mem_wdata;
    end
  end

endmodule

/* vtb_entry_ctrl.sv */
// entry control with valid, ready, operation, register, masks, byte tracking and status decode

`timescale 1ns/1ps

module vtb_entry_ctrl #(
  parameter int DATA_W  = vtb_pkg::DATA_W,
  parameter int BLK_NUM = vtb_pkg::BLK_NUM
) (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  input  logic                       create_vld,
  input  vtb_pkg::vtb_op_e           create_op,
  input  logic                       create_wready,
  input  logic [DATA_W/8-1:0]        create_mask,
  input  logic [DATA_W/8-1:0]        create_vl_mask,
  input  logic [vtb_pkg::VREG_W-1:0] create_vreg,
  input  logic [BLK_NUM-1:0]         lsu_wen,
  input  logic                       wb_done,
  input  logic                       fwd_done,
  input  logic                       flush,
  input  logic                       fwd_hit,
  output logic                       fwd_pend,
  output logic                       fwd_vld,
  output logic [DATA_W/8-1:0]        active_mask,
  output logic [DATA_W/8-1:0]        merge_mask,
  output logic [vtb_pkg::VREG_W-1:0] entry_vreg,
  output logic [DATA_W/8-1:0]        vl_mask,
  output logic [DATA_W/8-1:0]        vm_mask,
  output logic                       entry_vld,
  output logic                       st_vld,
  output logic                       wdata_ready,
  output logic                       wdata_vld,
  output logic                       wb_ready,
  output logic                       wb_vld,
  output logic                       all_wb,
  output logic                       vload_vld
);

  import vtb_pkg::*;

  localparam int BYTE_W   = DATA_W / 8;
  localparam int BLK_BYTE = BYTE_W / BLK_NUM;

  vtb_op_e           entry_op;
  logic              entry_ready;
  logic [BYTE_W-1:0] bytes_ret;
  logic [BYTE_W-1:0] wen_bytes;
  logic              create_st;
  logic              entry_st;

  assign create_st = (create_op == OP_STORE) || (create_op == OP_FLS_STORE);
  assign entry_st  = (entry_op == OP_STORE) || (entry_op == OP_FLS_STORE);

  // ====================
  // entry state
  // ====================

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (wb_done || fwd_done || flush)
      entry_vld <= 1'b0;
    else if (create_vld)
      entry_vld <= 1'b1;
  end

  // write data is ready at create only for stores
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_op    <= OP_LOAD;
      entry_ready <= 1'b0;
    end
    else if (create_vld)
    begin
      entry_op    <= create_op;
      entry_ready <= create_wready && create_st;
    end
    else if (fwd_vld)
      entry_ready <= 1'b1;
  end

  always_ff @(posedge entry_clk)
  begin
    if (create_vld)
      entry_vreg <= create_vreg;
  end

  // ====================
  // masks
  // ====================

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      vm_mask <= '1;
      vl_mask <= '1;
    end
    else if (wb_done)
    begin
      vm_mask <= '1;
      vl_mask <= '1;
    end
    else if (create_vld)
    begin
      vm_mask <= create_mask;
      vl_mask <= create_vl_mask;
    end
  end

  // one lsu_wen bit covers the bytes of its block
  always_comb
  begin
    wen_bytes = '0;
    for (int i = 0; i < BLK_NUM; i++)
    begin
      wen_bytes[i*BLK_BYTE +: BLK_BYTE] = {BLK_BYTE{lsu_wen[i]}};
    end
  end

  // bytes returned by memory since the last write-back
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bytes_ret <= '0;
    else if (wb_done)
      bytes_ret <= wen_bytes;
    else if (|lsu_wen)
      bytes_ret <= bytes_ret | wen_bytes;
  end

  assign active_mask = (entry_vld && !entry_ready) ? vm_mask : '1;
  assign merge_mask  = bytes_ret & create_mask;

  // ====================
  // forwarding and status
  // ====================

  assign fwd_pend = entry_vld && (entry_op == OP_FLS_STORE) && !entry_ready;
  assign fwd_vld  = fwd_pend && fwd_hit;

  assign st_vld      = entry_vld && entry_st;
  assign wdata_ready = entry_ready || fwd_vld;
  assign wdata_vld   = entry_vld && entry_st && entry_ready;
  assign wb_ready    = entry_vld && !entry_st && entry_ready;
  // no segment write-back term
  assign wb_vld      = wb_ready;
  assign all_wb      = !(entry_vld && !entry_st);
  assign vload_vld   = entry_vld && (entry_op == OP_LOAD);

endmodule

/* vtb_entry.sv */
// vector load/store buffer entry top with control, forward match and data blocks

`timescale 1ns/1ps

module vtb_entry #(
  parameter int DATA_W  = vtb_pkg::DATA_W,
  parameter int BLK_NUM = vtb_pkg::BLK_NUM
) (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  // create
  input  logic                       create_vld,
  input  vtb_pkg::vtb_op_e           create_op,
  input  logic                       create_wready,
  input  logic [DATA_W-1:0]          create_data,
  input  logic [DATA_W/8-1:0]        create_mask,
  input  logic [DATA_W/8-1:0]        create_vl_mask,
  input  logic [vtb_pkg::VREG_W-1:0] create_vreg,
  // memory write
  input  logic [BLK_NUM-1:0]         lsu_wen,
  input  logic [DATA_W-1:0]          lsu_wen_data,
  // forward sources
  input  logic                       fls_wb_vld,
  input  logic [vtb_pkg::FREG_W-1:0] fls_reg,
  input  logic [DATA_W-1:0]          fls_data,
  input  logic                       fp_wb_vld,
  input  logic [vtb_pkg::FREG_W-1:0] fp_wb_reg,
  input  logic [DATA_W-1:0]          fp_wb_data,
  // clear
  input  logic                       wb_done,
  input  logic                       fwd_done,
  input  logic                       flush,
  // status
  output logic                       entry_vld,
  output logic                       st_vld,
  output logic                       st_fwd_vld,
  output logic                       st_fwd_fp_bus,
  output logic                       wdata_ready,
  output logic                       wdata_vld,
  output logic                       wb_ready,
  output logic                       wb_vld,
  output logic                       all_wb,
  output logic                       vload_vld,
  // data
  output logic [DATA_W-1:0]          entry_data,
  output logic [vtb_pkg::VREG_W-1:0] entry_vreg,
  output logic [DATA_W/8-1:0]        vl_mask,
  output logic [DATA_W/8-1:0]        vm_mask
);

  localparam int BLK_W    = DATA_W / BLK_NUM;
  localparam int BLK_BYTE = BLK_W / 8;

  logic                  fwd_pend;
  logic                  fwd_hit;
  logic [DATA_W-1:0]     fwd_data;
  logic [DATA_W/8-1:0]   active_mask;
  logic [DATA_W/8-1:0]   merge_mask;

  // ====================
  // control
  // ====================

  vtb_entry_ctrl #(
    .DATA_W  (DATA_W),
    .BLK_NUM (BLK_NUM)
  ) i_ctrl (
    .entry_clk      (entry_clk),
    .cpurst_b       (cpurst_b),
    .create_vld     (create_vld),
    .create_op      (create_op),
    .create_wready  (create_wready),
    .create_mask    (create_mask),
    .create_vl_mask (create_vl_mask),
    .create_vreg    (create_vreg),
    .lsu_wen        (lsu_wen),
    .wb_done        (wb_done),
    .fwd_done       (fwd_done),
    .flush          (flush),
    .fwd_hit        (fwd_hit),
    .fwd_pend       (fwd_pend),
    .fwd_vld        (st_fwd_vld),
    .active_mask    (active_mask),
    .merge_mask     (merge_mask),
    .entry_vreg     (entry_vreg),
    .vl_mask        (vl_mask),
    .vm_mask        (vm_mask),
    .entry_vld      (entry_vld),
    .st_vld         (st_vld),
    .wdata_ready    (wdata_ready),
    .wdata_vld      (wdata_vld),
    .wb_ready       (wb_ready),
    .wb_vld         (wb_vld),
    .all_wb         (all_wb),
    .vload_vld      (vload_vld)
  );

  vtb_fwd_match #(
    .DATA_W (DATA_W)
  ) i_fwd_match (
    .fwd_pend   (fwd_pend),
    .fls_wb_vld (fls_wb_vld),
    .fls_reg    (fls_reg),
    .fls_data   (fls_data),
    .fp_wb_vld  (fp_wb_vld),
    .fp_wb_reg  (fp_wb_reg),
    .fp_wb_data (fp_wb_data),
    .entry_vreg (entry_vreg),
    .fwd_hit    (fwd_hit),
    .fp_sel     (st_fwd_fp_bus),
    .fwd_data   (fwd_data)
  );

  // ====================
  // data blocks
  // ====================

  for (genvar i = 0; i < BLK_NUM; i++)
  begin : g_blk
    vtb_data_blk #(
      .BLK_W (BLK_W)
    ) i_data_blk (
      .entry_clk   (entry_clk),
      .create_vld  (create_vld),
      .wen         (lsu_wen[i]),
      .fwd_vld     (st_fwd_vld),
      .create_data (create_data[i*BLK_W +: BLK_W]),
      .lsu_data    (lsu_wen_data[i*BLK_W +: BLK_W]),
      .fwd_data    (fwd_data[i*BLK_W +: BLK_W]),
      .create_mask (create_mask[i*BLK_BYTE +: BLK_BYTE]),
      .merge_mask  (merge_mask[i*BLK_BYTE +: BLK_BYTE]),
      .active_mask (active_mask[i*BLK_BYTE +: BLK_BYTE]),
      .blk_data    (entry_data[i*BLK_W +: BLK_W])
    );
  end

endmodule

/* tb_vtb_entry_sva.sv */
// bound assertions on entry reset, create, clear and store forwarding

`timescale 1ns/1ps

module tb_vtb_entry_sva #(
  parameter int DATA_W = vtb_pkg::DATA_W
) (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  input  logic                       create_vld,
  input  logic [DATA_W/8-1:0]        create_mask,
  input  logic [vtb_pkg::VREG_W-1:0] create_vreg,
  input  logic                       fls_wb_vld,
  input  logic [vtb_pkg::FREG_W-1:0] fls_reg,
  input  logic                       fp_wb_vld,
  input  logic [vtb_pkg::FREG_W-1:0] fp_wb_reg,
  input  logic [DATA_W-1:0]          fp_wb_data,
  input  logic                       wb_done,
  input  logic                       fwd_done,
  input  logic                       flush,
  input  logic                       entry_vld,
  input  logic                       st_fwd_vld,
  input  logic                       st_fwd_fp_bus,
  input  logic                       wdata_vld,
  input  logic                       all_wb,
  input  logic [DATA_W-1:0]          entry_data,
  input  logic [vtb_pkg::VREG_W-1:0] entry_vreg,
  input  logic [DATA_W/8-1:0]        vm_mask
);

  // raised by any failing assertion
  logic sva_err;
  logic clr;

  initial sva_err = 1'b0;

  assign clr = wb_done || fwd_done || flush;

  task automatic note_fail(input string what);
    begin
      sva_err = 1'b1;
      $error("%s", what);
    end
  endtask

  // ====================
  // entry state
  // ====================

  a_reset: assert property (@(posedge entry_clk)
    $rose(cpurst_b) |-> !entry_vld && all_wb && (vm_mask == '1))
    else note_fail("entry not in its reset state when reset was released");

  a_create: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    create_vld && !clr |=> entry_vld && (entry_vreg == $past(create_vreg))
      && (vm_mask == $past(create_mask)))
    else note_fail("create did not load valid, register and mask");

  a_clear: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    clr |=> !entry_vld)
    else note_fail("entry still valid after a clear strobe");

  // ====================
  // forwarding
  // ====================

  // a forward needs a bus that carries the entry's register group
  a_fwd_match: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    st_fwd_vld |-> (fp_wb_vld && (fp_wb_reg == entry_vreg[6:2]))
      || (fls_wb_vld && (fls_reg == entry_vreg[6:2])))
    else note_fail("forward seen without a matching write-back bus");

  a_fwd_fp: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    st_fwd_fp_bus |-> st_fwd_vld && fp_wb_vld && (fp_wb_reg == entry_vreg[6:2]))
    else note_fail("fp bus reported without a forward from it");

  a_fwd_data: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    st_fwd_fp_bus && !create_vld |=> entry_data == $past(fp_wb_data))
    else note_fail("entry data does not hold the forwarded fp bus data");

  a_fwd_wvld: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    st_fwd_vld && !create_vld && !clr |=> wdata_vld)
    else note_fail("store not write-data valid after forwarding");

endmodule

/* tb_vtb_entry.sv */
// testbench for the vector load/store buffer entry with stimulus sequences and watchdog

`timescale 1ns/1ps

module tb_vtb_entry;

  import vtb_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYC    = 16;
  localparam int SEED       = 32'h48a5_0aad;
  localparam int BLK_BYTE   = BYTE_NUM / BLK_NUM;
  localparam int N_CREATE   = 12;
  localparam int N_MEMW     = 2;
  localparam int N_FWD      = 3;
  // sequence lengths in cycles, margin added below
  localparam int RUN_CYC    = RST_CYC + 3 + N_CREATE * 2 + N_MEMW * 6 + N_FWD * 6 + BLK_NUM * 5;
  localparam int TIMEOUT_NS = (RUN_CYC + 40) * CLK_PERIOD;

  logic                entry_clk, cpurst_b;
  logic                create_vld, create_wready;
  vtb_op_e             create_op;
  logic [DATA_W-1:0]   create_data, lsu_wen_data, fls_data, fp_wb_data, entry_data;
  logic [BYTE_NUM-1:0] create_mask, create_vl_mask, vl_mask, vm_mask;
  logic [VREG_W-1:0]   create_vreg, entry_vreg;
  logic [BLK_NUM-1:0]  lsu_wen;
  logic                fls_wb_vld, fp_wb_vld, wb_done, fwd_done, flush;
  logic [FREG_W-1:0]   fls_reg, fp_wb_reg;
  logic                entry_vld, st_vld, st_fwd_vld, st_fwd_fp_bus, wdata_ready, wdata_vld;
  logic                wb_ready, wb_vld, all_wb, vload_vld;
  // bytes returned by memory since the last write-back
  logic [BYTE_NUM-1:0] ret_bytes;

  vtb_entry #(.DATA_W(DATA_W), .BLK_NUM(BLK_NUM)) i_vtb_entry (.*);

  bind vtb_entry tb_vtb_entry_sva i_sva (.*);

  always #(CLK_PERIOD / 2) entry_clk = ~entry_clk;

  initial
  begin
    #(TIMEOUT_NS);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("sim failed");
    $fatal(1);
  end

  always @(negedge entry_clk)
  begin
    if (i_vtb_entry.i_sva.sva_err)
    begin
      $display("ERROR at %0t: a bound assertion on the entry failed", $time);
      $display("sim failed");
      $fatal(1);
    end
  end

  // ====================
  // helpers
  // ====================

  function automatic logic [BYTE_NUM-1:0] expand_wen(input logic [BLK_NUM-1:0] wen);
    logic [BYTE_NUM-1:0] sel;
    begin
      sel = '0;
      for (int i = 0; i < BLK_NUM; i++)
        if (wen[i])
          sel[i*BLK_BYTE +: BLK_BYTE] = '1;
      return sel;
    end
  endfunction

  // bytes under sel come from upd
  function automatic logic [DATA_W-1:0] pick_bytes(input logic [DATA_W-1:0] base,
                                                   input logic [DATA_W-1:0] upd,
                                                   input logic [BYTE_NUM-1:0] sel);
    logic [DATA_W-1:0] res;
    begin
      res = base;
      for (int b = 0; b < BYTE_NUM; b++)
        if (sel[b])
          res[b*8 +: 8] = upd[b*8 +: 8];
      return res;
    end
  endfunction

  function automatic logic [DATA_W-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  task automatic check_vec(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    begin
      assert (act === exp)
      else
      begin
        $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
        $display("sim failed");
        $fatal(1);
      end
    end
  endtask

  // one clock, returned-byte tracking follows the driven inputs
  task automatic tick();
    begin
      if (wb_done)
        ret_bytes = expand_wen(lsu_wen);
      else if (|lsu_wen)
        ret_bytes = ret_bytes | expand_wen(lsu_wen);
      @(negedge entry_clk);
    end
  endtask

  task automatic create_entry(input vtb_op_e op, input logic wready,
                              input logic [DATA_W-1:0] data, input logic [BYTE_NUM-1:0] mask,
                              input logic [BYTE_NUM-1:0] vlm, input logic [VREG_W-1:0] vreg);
    begin
      create_vld     = 1'b1;
      create_op      = op;
      create_wready  = wready;
      create_data    = data;
      create_mask    = mask;
      create_vl_mask = vlm;
      create_vreg    = vreg;
      tick();
      create_vld     = 1'b0;
    end
  endtask

  // kind 0 flush, 1 wb_done, 2 fwd_done
  task automatic clear_entry(input int kind);
    begin
      flush    = (kind == 0);
      wb_done  = (kind == 1);
      fwd_done = (kind == 2);
      tick();
      {flush, wb_done, fwd_done} = '0;
    end
  endtask

  // ====================
  // sequences
  // ====================

  initial
  begin
    vtb_op_e             op;
    logic [DATA_W-1:0]   exp_data, old_data, cdat, wdat;
    logic [BYTE_NUM-1:0] mask, vlm, keep_old, take_lsu;
    logic [VREG_W-1:0]   vreg;
    logic                is_st, wrdy, rdy;
    void'($urandom(SEED));
    entry_clk = 1'b0;
    cpurst_b  = 1'b0;
    create_op = OP_LOAD;
    {create_vld, create_wready, create_data, create_mask, create_vl_mask, create_vreg} = '0;
    {lsu_wen, lsu_wen_data, fls_wb_vld, fls_reg, fls_data} = '0;
    {fp_wb_vld, fp_wb_reg, fp_wb_data, wb_done, fwd_done, flush} = '0;
    ret_bytes = '0;
    repeat (RST_CYC) @(posedge entry_clk);
    @(negedge entry_clk);
    cpurst_b = 1'b1;
    tick();

    check_vec("entry_vld", 0, 64'(entry_vld));
    check_vec("st_vld", 0, 64'(st_vld));
    check_vec("wdata_vld", 0, 64'(wdata_vld));
    check_vec("wb_vld", 0, 64'(wb_vld));
    check_vec("all_wb", 1, 64'(all_wb));
    check_vec("vm_mask", 64'hff, 64'(vm_mask));
    check_vec("vl_mask", 64'hff, 64'(vl_mask));

    // every operation against every clear strobe
    for (int i = 0; i < N_CREATE; i++)
    begin
      op    = vtb_op_e'(i % 4);
      is_st = (op == OP_STORE) || (op == OP_FLS_STORE);
      // each operation sees both create_wready values
      wrdy  = ((i / 4) % 2 == 1);
      rdy   = wrdy && is_st;
      vreg  = 7'($urandom);
      mask  = 8'($urandom);
      vlm   = 8'($urandom);
      create_entry(op, wrdy, rand64(), mask, vlm, vreg);
      check_vec("entry_vld", 1, 64'(entry_vld));
      check_vec("entry_vreg", 64'(vreg), 64'(entry_vreg));
      check_vec("vm_mask", 64'(mask), 64'(vm_mask));
      check_vec("vl_mask", 64'(vlm), 64'(vl_mask));
      check_vec("st_vld", 64'(is_st), 64'(st_vld));
      check_vec("wdata_ready", 64'(rdy), 64'(wdata_ready));
      check_vec("wdata_vld", 64'(is_st && rdy), 64'(wdata_vld));
      check_vec("wb_ready", 64'(!is_st && rdy), 64'(wb_ready));
      check_vec("wb_vld", 64'(!is_st && rdy), 64'(wb_vld));
      check_vec("all_wb", 64'(is_st), 64'(all_wb));
      check_vec("vload_vld", 64'(op == OP_LOAD), 64'(vload_vld));
      clear_entry(i % 3);
      check_vec("entry_vld", 0, 64'(entry_vld));
      if (i % 3 == 1)
      begin
        check_vec("vm_mask", 64'hff, 64'(vm_mask));
        check_vec("vl_mask", 64'hff, 64'(vl_mask));
      end
    end

    // masked memory write, one block per cycle
    for (int r = 0; r < N_MEMW; r++)
    begin
      clear_entry(1);
      mask     = 8'($urandom);
      exp_data = rand64();
      create_entry(r == 0 ? OP_LOAD : OP_FLS_LOAD, 1'b0, exp_data, mask, 8'hff, 7'($urandom));
      check_vec("entry_data", exp_data, entry_data);
      for (int k = 0; k < BLK_NUM; k++)
      begin
        wdat         = rand64();
        lsu_wen      = BLK_NUM'(1) << k;
        lsu_wen_data = wdat;
        tick();
        lsu_wen  = '0;
        exp_data = pick_bytes(exp_data, wdat, mask & expand_wen(BLK_NUM'(1) << k));
        check_vec("entry_data", exp_data, entry_data);
      end
    end

    // store forwarding, mode 0 fp bus, 1 both buses, 2 fls bus
    for (int m = 0; m < N_FWD; m++)
    begin
      clear_entry(1);
      vreg = 7'($urandom);
      create_entry(OP_FLS_STORE, 1'b0, rand64(), 8'hff, 8'hff, vreg);
      check_vec("wdata_ready", 0, 64'(wdata_ready));
      fp_wb_vld = 1'b1;
      fp_wb_reg = vreg[6:2] ^ 5'd1;
      #1;
      check_vec("st_fwd_vld", 0, 64'(st_fwd_vld));
      tick();
      fp_wb_vld  = (m != 2);
      fp_wb_reg  = vreg[6:2];
      fp_wb_data = rand64();
      fls_wb_vld = (m != 0);
      fls_reg    = vreg[6:2];
      fls_data   = rand64();
      exp_data   = (m != 2) ? fp_wb_data : fls_data;
      #1;
      check_vec("st_fwd_vld", 1, 64'(st_fwd_vld));
      check_vec("st_fwd_fp_bus", 64'(m != 2), 64'(st_fwd_fp_bus));
      check_vec("wdata_ready", 1, 64'(wdata_ready));
      tick();
      {fp_wb_vld, fls_wb_vld} = '0;
      check_vec("entry_data", exp_data, entry_data);
      check_vec("wdata_vld", 1, 64'(wdata_vld));
      // ready entry ignores a later match
      fp_wb_vld  = 1'b1;
      fp_wb_data = rand64();
      #1;
      check_vec("st_fwd_vld", 0, 64'(st_fwd_vld));
      tick();
      fp_wb_vld = 1'b0;
      check_vec("entry_data", exp_data, entry_data);
      clear_entry(2);
    end

    // create merge with bytes already returned by memory
    for (int k = 0; k < BLK_NUM; k++)
    begin
      clear_entry(1);
      old_data = rand64();
      create_entry(OP_LOAD, 1'b0, old_data, 8'hff, 8'hff, 7'($urandom));
      wdat         = rand64();
      lsu_wen      = BLK_NUM'(1) << k;
      lsu_wen_data = wdat;
      tick();
      old_data = pick_bytes(old_data, wdat, expand_wen(lsu_wen));
      lsu_wen  = '0;
      check_vec("entry_data", old_data, entry_data);
      clear_entry(0);
      // another block returns data together with the create
      mask         = 8'($urandom) | (BYTE_NUM'(1) << (k * BLK_BYTE));
      cdat         = rand64();
      wdat         = rand64();
      lsu_wen      = BLK_NUM'(1) << ((k + 2) % BLK_NUM);
      lsu_wen_data = wdat;
      take_lsu     = expand_wen(lsu_wen) & mask;
      keep_old     = ~expand_wen(lsu_wen) & ret_bytes & mask;
      exp_data     = pick_bytes(pick_bytes(cdat, old_data, keep_old), wdat, take_lsu);
      create_entry(OP_LOAD, 1'b0, cdat, mask, 8'hff, 7'($urandom));
      lsu_wen = '0;
      check_vec("entry_data", exp_data, entry_data);
    end

    tick();
    tick();
    if (i_vtb_entry.i_sva.sva_err)
    begin
      $display("ERROR at %0t: a bound assertion on the entry failed", $time);
      $display("sim failed");
      $fatal(1);
    end
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

/* project.f */
vtb_pkg.sv
vtb_fwd_match.sv
vtb_data_blk.sv
vtb_entry_ctrl.sv
vtb_entry.sv
tb_vtb_entry_sva.sv
tb_vtb_entry.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vtb_entry \
  -f project.f -o tb_vtb_entry
./obj_dir/tb_vtb_entry +verilator+error+limit+100 | tee sim.log
if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation PASSED"
